// File: build.f
hw/gmii_pkg.sv
hw/eth_frame_pkg.sv
hw/eth_byte_if.sv
hw/gmii_rx_phy_if.sv
hw/eth_rx_framer.sv
hw/eth_rx_fcs_check.sv
hw/gmii_rx_top.sv
testbench/tb_clk_gen.sv
testbench/tb_gmii_rx.sv

// File: hw/eth_byte_if.sv
// Frame byte stream between framer and FCS checker
// one byte per cycle while valid, no ready
`timescale 1ns/1ps

interface eth_byte_if;
    import gmii_pkg::*;

    gmii_byte_t data;
    logic       valid;
    // first byte after the SFD
    logic       start;
    // final byte of the frame, FCS included
    logic       last;
    // only meaningful with last, rx_er seen anywhere in the frame
    logic       err;

    // framer side
    modport src (output data, valid, start, last, err);

    // checker side
    modport dst (input data, valid, start, last, err);

endinterface

// File: hw/eth_frame_pkg.sv
// Ethernet frame level definitions
// CRC-32 constants, the length type and the per-frame status word
package eth_frame_pkg;

    // frame length in bytes, FCS included
    typedef logic [11:0] eth_len_t;

    // reflected form of 0x04C11DB7, data shifted lsb first
    localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;

    // register preset at frame start
    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;

    // register value once data and a correct FCS have been shifted in
    localparam logic [31:0] CRC_RESIDUE = 32'hDEBB_20E3;

    // one word per received frame, 16 bits
    typedef struct packed {
        logic     good;     // no flag below set
        logic     bad_fcs;  // residue mismatch
        logic     err;      // rx_er somewhere in the frame
        logic     runt;     // below minimum length
        eth_len_t len;
    } eth_rx_status_t;

endpackage

// File: hw/eth_rx_fcs_check.sv
// Ethernet receive FCS and length checker
// CRC-32 over all frame bytes, one status pulse per frame, bytes passed on
`timescale 1ns/1ps

module eth_rx_fcs_check #(
    parameter int MIN_FRAME_LEN = 64
) (
    input  logic                          mac_gmii_rx_clk,
    input  logic                          rx_rst,
    eth_byte_if.dst                       in,
    output gmii_pkg::gmii_byte_t          rx_data,
    output logic                          rx_valid,
    output logic                          rx_start,
    output logic                          rx_last,
    output logic                          stat_valid,
    output eth_frame_pkg::eth_rx_status_t stat
);
    import eth_frame_pkg::*;

    logic [31:0]    crc_q;
    logic [31:0]    crc_next;
    eth_len_t       len_q;
    eth_len_t       len_next;
    eth_rx_status_t stat_next;

    // one byte through the reflected CRC with the lsb first
    function automatic logic [31:0] crc_byte(input logic [31:0] crc_in, input logic [7:0] d);
        logic [31:0] c;
        int          i;
        c = crc_in;
        for (i = 0; i < 8; i++) begin
            c = (c >> 1) ^ ((c[0] ^ d[i]) ? CRC_POLY : 32'h0);
        end
        return c;
    endfunction

    // the start byte restarts from the preset
    always_comb begin
        crc_next = crc_byte(in.start ? CRC_INIT : crc_q, in.data);
        len_next = (in.start ? eth_len_t'(0) : len_q) + eth_len_t'(1);

        stat_next.bad_fcs = (crc_next != CRC_RESIDUE);
        stat_next.err     = in.err;
        stat_next.runt    = (len_next < eth_len_t'(MIN_FRAME_LEN));
        stat_next.len     = len_next;
        stat_next.good    = !(stat_next.bad_fcs || stat_next.err || stat_next.runt);
    end

    // output strobes
    always_ff @(posedge mac_gmii_rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            rx_valid   <= 1'b0;
            rx_start   <= 1'b0;
            rx_last    <= 1'b0;
            stat_valid <= 1'b0;
        end else begin
            rx_valid   <= in.valid;
            rx_start   <= in.valid && in.start;
            rx_last    <= in.valid && in.last;
            stat_valid <= in.valid && in.last;
        end
    end

    // running CRC, count and the output byte
    always_ff @(posedge mac_gmii_rx_clk) begin
        if (in.valid) begin
            crc_q <= crc_next;
            len_q <= len_next;
        end
        rx_data <= in.data;
        // status held until the next frame ends
        if (in.valid && in.last) begin
            stat <= stat_next;
        end
    end

    // one single-cycle status pulse per frame, on the forwarded last byte
    a_stat_with_last: assert property (
        @(posedge mac_gmii_rx_clk) disable iff (rx_rst)
        stat_valid |-> rx_last ##1 !stat_valid
    ) else $error("stat_valid is not a single pulse on a last byte");

endmodule

// File: hw/eth_rx_framer.sv
// Ethernet receive framer
// strips preamble and SFD, emits frame bytes marked with start and last
`timescale 1ns/1ps

module eth_rx_framer (
    input  logic                 mac_gmii_rx_clk,
    input  logic                 rx_rst,
    input  gmii_pkg::gmii_byte_t rxd_q,
    input  logic                 rx_dv_q,
    input  logic                 rx_er_q,
    eth_byte_if.src              out
);
    import gmii_pkg::*;

    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_PREAMBLE = 2'd1;
    localparam logic [1:0] ST_DATA     = 2'd2;
    localparam logic [1:0] ST_DISCARD  = 2'd3;

    logic [1:0] state;
    // one byte in hand until its successor or the end arrives
    gmii_byte_t hold_data;
    logic       hold_valid;
    logic       first_pend;
    logic       err_sticky;
    // tracks an open frame on the output side
    logic       frame_open;

    always_ff @(posedge mac_gmii_rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            state      <= ST_IDLE;
            hold_valid <= 1'b0;
            first_pend <= 1'b0;
            err_sticky <= 1'b0;
            out.valid  <= 1'b0;
            out.start  <= 1'b0;
            out.last   <= 1'b0;
        end else begin
            out.valid <= 1'b0;
            out.start <= 1'b0;
            out.last  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // a frame must open with a preamble byte
                    if (rx_dv_q) begin
                        state <= (rxd_q == GMII_PREAMBLE) ? ST_PREAMBLE : ST_DISCARD;
                    end
                end
                ST_PREAMBLE: begin
                    if (!rx_dv_q) begin
                        state <= ST_IDLE;
                    end else if (rxd_q == GMII_SFD) begin
                        state      <= ST_DATA;
                        hold_valid <= 1'b0;
                        first_pend <= 1'b1;
                        err_sticky <= 1'b0;
                    end else if (rxd_q != GMII_PREAMBLE) begin
                        state <= ST_DISCARD;
                    end
                end
                ST_DATA: begin
                    // held byte goes out and is marked last if dv just dropped
                    // an empty frame holds nothing and sends nothing
                    out.valid <= hold_valid;
                    out.start <= hold_valid && first_pend;
                    out.last  <= hold_valid && !rx_dv_q;
                    if (hold_valid) begin
                        first_pend <= 1'b0;
                    end
                    if (rx_dv_q) begin
                        hold_valid <= 1'b1;
                        err_sticky <= err_sticky | rx_er_q;
                    end else begin
                        hold_valid <= 1'b0;
                        state      <= ST_IDLE;
                    end
                end
                default: begin
                    // after a bad preamble wait for the line to go quiet
                    if (!rx_dv_q) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // byte path
    always_ff @(posedge mac_gmii_rx_clk) begin
        if (state == ST_DATA && rx_dv_q) begin
            hold_data <= rxd_q;
        end
        out.data <= hold_data;
        // error summary only rides on the last byte
        out.err  <= (state == ST_DATA) && !rx_dv_q && err_sticky;
    end

    always_ff @(posedge mac_gmii_rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            frame_open <= 1'b0;
        end else if (out.valid) begin
            frame_open <= !out.last;
        end
    end

    // every output byte was taken while the line carried a frame
    a_valid_in_frame: assert property (
        @(posedge mac_gmii_rx_clk) disable iff (rx_rst)
        out.valid |-> $past(rx_dv_q, 2)
    ) else $error("framer emitted a byte outside a frame");

    a_last_after_start: assert property (
        @(posedge mac_gmii_rx_clk) disable iff (rx_rst)
        out.valid && out.last |-> out.start || frame_open
    ) else $error("framer emitted last without a preceding start");

endmodule

// File: hw/gmii_pkg.sv
// GMII receive line definitions
// data byte type plus the preamble and start-of-frame codes
package gmii_pkg;

    // one byte as it appears on rxd
    typedef logic [7:0] gmii_byte_t;

    // repeated before each frame, at least once
    localparam gmii_byte_t GMII_PREAMBLE = 8'h55;

    // start-of-frame delimiter, closes the preamble
    // first data byte follows directly
    localparam gmii_byte_t GMII_SFD = 8'hD5;

endpackage

// File: hw/gmii_rx_phy_if.sv
// GMII receive input stage
// one register stage on the pins plus the local reset synchronizer
`timescale 1ns/1ps

module gmii_rx_phy_if #(
    parameter int RST_SYNC_STAGES = 4
) (
    input  logic                 mac_gmii_rx_clk,
    input  logic                 rst,
    input  gmii_pkg::gmii_byte_t phy_gmii_rxd,
    input  logic                 phy_gmii_rx_dv,
    input  logic                 phy_gmii_rx_er,
    output logic                 rx_rst,
    output gmii_pkg::gmii_byte_t rxd_q,
    output logic                 rx_dv_q,
    output logic                 rx_er_q
);

    // all ones while rst is high, zeros shift in from the top
    logic [RST_SYNC_STAGES-1:0] rst_sync;

    // assert at once, release on the clock
    always_ff @(posedge mac_gmii_rx_clk or posedge rst) begin
        if (rst) begin
            rst_sync <= '1;
        end else begin
            rst_sync <= rst_sync >> 1;
        end
    end

    // lsb clears after RST_SYNC_STAGES edges
    assign rx_rst = rst_sync[0];

    // pin sampling, placed close to the pads
    // every sample shows up on the _q side one cycle later
    always_ff @(posedge mac_gmii_rx_clk) begin
        rxd_q   <= phy_gmii_rxd;
        rx_dv_q <= phy_gmii_rx_dv;
        rx_er_q <= phy_gmii_rx_er;
    end

    // local reset must cover the whole synchronizer depth once rst is gone
    a_rst_hold: assert property (
        @(posedge mac_gmii_rx_clk) disable iff (rst)
        $fell(rx_rst) |-> $past(rx_rst, RST_SYNC_STAGES)
    ) else $error("rx_rst released after fewer than %0d cycles", RST_SYNC_STAGES);

endmodule

// File: hw/gmii_rx_top.sv
// Gigabit Ethernet receive path, top level
// input stage, framer and FCS checker, status split onto plain ports
`timescale 1ns/1ps

module gmii_rx_top #(
    parameter int RST_SYNC_STAGES = 4,
    parameter int MIN_FRAME_LEN   = 64
) (
    input  logic                     mac_gmii_rx_clk,
    input  logic                     rst,
    input  gmii_pkg::gmii_byte_t     phy_gmii_rxd,
    input  logic                     phy_gmii_rx_dv,
    input  logic                     phy_gmii_rx_er,
    output gmii_pkg::gmii_byte_t     rx_data,
    output logic                     rx_valid,
    output logic                     rx_start,
    output logic                     rx_last,
    output logic                     stat_valid,
    output logic                     stat_good,
    output logic                     stat_bad_fcs,
    output logic                     stat_err,
    output logic                     stat_runt,
    output eth_frame_pkg::eth_len_t  stat_len
);
    import gmii_pkg::*;
    import eth_frame_pkg::*;

    logic           rx_rst;
    gmii_byte_t     rxd_q;
    logic           rx_dv_q;
    logic           rx_er_q;
    eth_rx_status_t stat;

    // framer to checker byte stream
    eth_byte_if byte_if ();

    gmii_rx_phy_if #(
        .RST_SYNC_STAGES (RST_SYNC_STAGES)
    ) u_phy_if (
        .mac_gmii_rx_clk (mac_gmii_rx_clk),
        .rst             (rst),
        .phy_gmii_rxd    (phy_gmii_rxd),
        .phy_gmii_rx_dv  (phy_gmii_rx_dv),
        .phy_gmii_rx_er  (phy_gmii_rx_er),
        .rx_rst          (rx_rst),
        .rxd_q           (rxd_q),
        .rx_dv_q         (rx_dv_q),
        .rx_er_q         (rx_er_q)
    );

    eth_rx_framer u_framer (
        .mac_gmii_rx_clk (mac_gmii_rx_clk),
        .rx_rst          (rx_rst),
        .rxd_q           (rxd_q),
        .rx_dv_q         (rx_dv_q),
        .rx_er_q         (rx_er_q),
        .out             (byte_if.src)
    );

    eth_rx_fcs_check #(
        .MIN_FRAME_LEN (MIN_FRAME_LEN)
    ) u_fcs_check (
        .mac_gmii_rx_clk (mac_gmii_rx_clk),
        .rx_rst          (rx_rst),
        .in              (byte_if.dst),
        .rx_data         (rx_data),
        .rx_valid        (rx_valid),
        .rx_start        (rx_start),
        .rx_last         (rx_last),
        .stat_valid      (stat_valid),
        .stat            (stat)
    );

    // status word out as separate pins
    assign stat_good    = stat.good;
    assign stat_bad_fcs = stat.bad_fcs;
    assign stat_err     = stat.err;
    assign stat_runt    = stat.runt;
    assign stat_len     = stat.len;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the GMII receive testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f build.f --top-module tb_gmii_rx --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_gmii_rx 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: testbench/tb_clk_gen.sv
// Testbench clock and reset source
// 10 ns clock, rst held for the first 8 cycles
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 8
) (
    output logic mac_gmii_rx_clk,
    output logic rst
);

    initial begin
        mac_gmii_rx_clk = 1'b0;
        forever #(HALF_PERIOD) mac_gmii_rx_clk = ~mac_gmii_rx_clk;
    end

    // released on a falling edge, like the other inputs
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge mac_gmii_rx_clk);
        @(negedge mac_gmii_rx_clk);
        rst = 1'b0;
    end

endmodule

// File: testbench/tb_gmii_rx.sv
// Testbench for the GMII receive path
// random frames with injected faults, outputs checked against a queue model
`timescale 1ns/1ps

module tb_gmii_rx;
    import gmii_pkg::*;
    import eth_frame_pkg::*;

    localparam int N_TESTS      = 20;
    localparam int K_GOOD       = 0;
    localparam int K_BAD_FCS    = 1;
    localparam int K_RX_ERR     = 2;
    localparam int K_RUNT       = 3;
    localparam int K_BAD_PRE    = 4;
    // pipeline latency plus margin
    localparam int DRAIN_CYCLES = 8;

    logic       mac_gmii_rx_clk;
    logic       rst;
    gmii_byte_t rxd;
    logic       rx_dv;
    logic       rx_er;
    gmii_byte_t rx_data;
    logic       rx_valid;
    logic       rx_start;
    logic       rx_last;
    logic       stat_valid;
    logic       stat_good;
    logic       stat_bad_fcs;
    logic       stat_err;
    logic       stat_runt;
    eth_len_t   stat_len;

    integer     seed;
    int         errors;
    int         cycles;
    int         cycle_limit;
    // per test frame kind, length with FCS, preamble bytes and idle gap
    int         kind [N_TESTS];
    int         flen [N_TESTS];
    int         plen [N_TESTS];
    int         gap [N_TESTS];
    gmii_byte_t frame_buf [0:303];
    // expected bytes {start, last, data}
    logic [9:0]  byte_q [$];
    // expected status {good, bad_fcs, err, runt, len}
    logic [15:0] stat_q [$];

    tb_clk_gen u_clk_gen (
        .mac_gmii_rx_clk (mac_gmii_rx_clk),
        .rst             (rst)
    );

    gmii_rx_top UUT (
        .mac_gmii_rx_clk (mac_gmii_rx_clk),
        .rst             (rst),
        .phy_gmii_rxd    (rxd),
        .phy_gmii_rx_dv  (rx_dv),
        .phy_gmii_rx_er  (rx_er),
        .rx_data         (rx_data),
        .rx_valid        (rx_valid),
        .rx_start        (rx_start),
        .rx_last         (rx_last),
        .stat_valid      (stat_valid),
        .stat_good       (stat_good),
        .stat_bad_fcs    (stat_bad_fcs),
        .stat_err        (stat_err),
        .stat_runt       (stat_runt),
        .stat_len        (stat_len)
    );

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // all output strobes low while nothing is being sent
    task automatic expect_quiet();
        compare_value("rx_valid", 32'(rx_valid), 32'h0);
        compare_value("rx_start", 32'(rx_start), 32'h0);
        compare_value("rx_last", 32'(rx_last), 32'h0);
        compare_value("stat_valid", 32'(stat_valid), 32'h0);
    endtask

    function automatic int rand_range(input int lo, input int hi);
        logic [31:0] r;
        r = $random(seed);
        return lo + int'(r % (hi - lo + 1));
    endfunction

    // MSB-first CRC on bit-reversed bytes with the result reflected and inverted
    function automatic logic [31:0] fcs_of(input int n);
        logic [31:0] r;
        logic [31:0] fcs;
        logic        fb;
        int          k;
        int          b;
        r = 32'hFFFF_FFFF;
        for (k = 0; k < n; k++) begin
            for (b = 0; b < 8; b++) begin
                fb = r[31] ^ frame_buf[k][b];
                r  = {r[30:0], 1'b0} ^ (fb ? 32'h04C1_1DB7 : 32'h0);
            end
        end
        for (b = 0; b < 32; b++) begin
            fcs[b] = ~r[31-b];
        end
        return fcs;
    endfunction

    function automatic string kind_name(input int k);
        case (k)
            K_GOOD:    return "good frame";
            K_BAD_FCS: return "bad fcs";
            K_RX_ERR:  return "receive error";
            K_RUNT:    return "runt";
            default:   return "bad preamble";
        endcase
    endfunction

    task automatic drive_byte(input gmii_byte_t b, input logic dv, input logic er);
        @(negedge mac_gmii_rx_clk);
        rxd   = b;
        rx_dv = dv;
        rx_er = er;
    endtask

    task automatic send_frame(input int t);
        int          n;
        int          k;
        int          err_pos;
        int          bad_pos;
        logic [31:0] fcs;
        logic [31:0] r;
        logic        bad_fcs;
        logic        err;
        logic        runt;
        n = flen[t] - 4;
        for (k = 0; k < n; k++) begin
            r = $random(seed);
            frame_buf[k] = r[7:0];
        end
        fcs = fcs_of(n);
        bad_fcs = (kind[t] == K_BAD_FCS);
        if (bad_fcs) begin
            fcs = fcs ^ (32'h1 << rand_range(0, 31));
        end
        // FCS goes out low byte first
        for (k = 0; k < 4; k++) begin
            frame_buf[n+k] = fcs[8*k +: 8];
        end
        err  = (kind[t] == K_RX_ERR);
        runt = (flen[t] < 64);
        err_pos = err ? rand_range(0, n - 1) : -1;
        bad_pos = (kind[t] == K_BAD_PRE) ? rand_range(0, plen[t] - 1) : -1;
        // a broken preamble drops the whole frame
        if (kind[t] != K_BAD_PRE) begin
            for (k = 0; k < flen[t]; k++) begin
                byte_q.push_back({k == 0, k == flen[t] - 1, frame_buf[k]});
            end
            stat_q.push_back({!(bad_fcs || err || runt), bad_fcs, err, runt,
                              eth_len_t'(flen[t])});
        end
        for (k = 0; k < plen[t]; k++) begin
            if (k == bad_pos) begin
                do begin
                    r = $random(seed);
                end while (r[7:0] == GMII_PREAMBLE || r[7:0] == GMII_SFD);
                drive_byte(r[7:0], 1'b1, 1'b0);
            end else begin
                drive_byte(GMII_PREAMBLE, 1'b1, 1'b0);
            end
        end
        drive_byte(GMII_SFD, 1'b1, 1'b0);
        for (k = 0; k < flen[t]; k++) begin
            drive_byte(frame_buf[k], 1'b1, k == err_pos);
        end
        repeat (gap[t]) drive_byte(8'h00, 1'b0, 1'b0);
    endtask

    // outputs change on the rising edge and are sampled on the falling one
    always @(negedge mac_gmii_rx_clk) begin : output_monitor
        logic [9:0]  eb;
        logic [15:0] es;
        if (rx_valid === 1'b1) begin
            if (byte_q.size() == 0) begin
                errors++;
                $display("unexpected output byte at %0t with no frame pending", $time);
            end else begin
                eb = byte_q.pop_front();
                compare_value("rx_data", 32'(rx_data), 32'(eb[7:0]));
                compare_value("rx_start", 32'(rx_start), 32'(eb[9]));
                compare_value("rx_last", 32'(rx_last), 32'(eb[8]));
                compare_value("stat_valid", 32'(stat_valid), 32'(eb[8]));
            end
        end else if (stat_valid === 1'b1 || rx_start === 1'b1 || rx_last === 1'b1) begin
            errors++;
            $display("strobe at %0t without rx_valid", $time);
        end
        if (stat_valid === 1'b1 && rx_valid === 1'b1) begin
            if (stat_q.size() == 0) begin
                errors++;
                $display("unexpected status pulse at %0t", $time);
            end else begin
                es = stat_q.pop_front();
                compare_value("stat_good", 32'(stat_good), 32'(es[15]));
                compare_value("stat_bad_fcs", 32'(stat_bad_fcs), 32'(es[14]));
                compare_value("stat_err", 32'(stat_err), 32'(es[13]));
                compare_value("stat_runt", 32'(stat_runt), 32'(es[12]));
                compare_value("stat_len", 32'(stat_len), 32'(es[11:0]));
            end
        end
    end

    // hard stop on a hung run
    always @(posedge mac_gmii_rx_clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: run exceeded %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin : main
        int t;
        int total;
        int errs_before;
        int drain;
        seed        = 32'he0ac_3f13;
        errors      = 0;
        cycles      = 0;
        cycle_limit = 0;
        total       = 0;
        rxd         = 8'h00;
        rx_dv       = 1'b0;
        rx_er       = 1'b0;
        // directed kinds first and random kinds after them
        for (t = 0; t < N_TESTS; t++) begin
            if (t < 5 || t == 13) begin
                kind[t] = K_GOOD;
            end else if (t < 7) begin
                kind[t] = K_BAD_FCS;
            end else if (t < 9) begin
                kind[t] = K_RX_ERR;
            end else if (t < 12) begin
                kind[t] = K_RUNT;
            end else if (t == 12) begin
                kind[t] = K_BAD_PRE;
            end else begin
                kind[t] = rand_range(K_GOOD, K_BAD_PRE);
            end
            flen[t] = (kind[t] == K_RUNT) ? rand_range(8, 63) : rand_range(64, 300);
            plen[t] = rand_range(1, 7);
            gap[t]  = rand_range(12, 24);
            total   = total + flen[t] + plen[t] + 1 + gap[t];
        end
        cycle_limit = 2 * total + 100;

        // strobes sit low through reset and the idle time after it
        @(posedge mac_gmii_rx_clk);
        while (rst !== 1'b0) begin
            @(negedge mac_gmii_rx_clk);
            expect_quiet();
        end
        repeat (8) begin
            @(negedge mac_gmii_rx_clk);
            expect_quiet();
        end
        $display("test 0 reset: %s", (errors == 0) ? "ok" : "error");

        for (t = 0; t < N_TESTS; t++) begin
            errs_before = errors;
            send_frame(t);
            drain = 0;
            while ((byte_q.size() != 0 || stat_q.size() != 0) && drain < DRAIN_CYCLES) begin
                @(negedge mac_gmii_rx_clk);
                drain++;
            end
            if (byte_q.size() != 0 || stat_q.size() != 0) begin
                errors++;
                $display("missing output: %0d bytes and %0d status words never arrived",
                         byte_q.size(), stat_q.size());
                byte_q.delete();
                stat_q.delete();
            end
            $display("test %0d %s, %0d bytes: %s", t + 1, kind_name(kind[t]), flen[t],
                     (errors == errs_before) ? "ok" : "error");
        end

        $display("tests run %0d, errors %0d", N_TESTS + 1, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
